//--- jesd_tpl_adc_config.svh
// link geometry, sample widths, register addresses and id value of the adc transport layer
`ifndef JESD_TPL_ADC_CONFIG_SVH
`define JESD_TPL_ADC_CONFIG_SVH

// ****************************************
// link and sample geometry
// ****************************************
`define TPL_NUM_LANES 2
`define TPL_OCTETS_PER_BEAT 4
`define TPL_NUM_CHANNELS 2
`define TPL_SAMPLES_PER_CH 2
`define TPL_NP 16
`define TPL_N 14

// derived bus widths
`define TPL_LANE_W (`TPL_OCTETS_PER_BEAT * 8)
`define TPL_LINK_W (`TPL_NUM_LANES * `TPL_LANE_W)
`define TPL_CH_W (`TPL_SAMPLES_PER_CH * `TPL_NP)
`define TPL_ADC_W (`TPL_NUM_CHANNELS * `TPL_CH_W)

// ****************************************
// register map
// ****************************************
`define TPL_ID 32'h4a54_4c01
`define TPL_ADDR_ID 8'h00
`define TPL_ADDR_RST 8'h01
`define TPL_ADDR_CTRL0 8'h10
`define TPL_ADDR_STAT0 8'h18

`endif

//--- jesd_tpl_adc_pkg.sv
// package with the sample union, pn select enum and data format enum
`default_nettype none

`include "jesd_tpl_adc_config.svh"

package jesd_tpl_adc_pkg;

  // ****************************************
  // sample word
  // ****************************************

  // converter bits sit above the tail bits
  typedef struct packed {
    logic [`TPL_N-1:0] conv;
    logic [`TPL_NP-`TPL_N-1:0] tail;
  } tpl_sample_fld_t;

  // the pn checker sees the raw word, the formatter sees the fields
  typedef union packed {
    logic [`TPL_NP-1:0] word;
    tpl_sample_fld_t fld;
  } tpl_sample_u;

  // ****************************************
  // control encodings
  // ****************************************

  // matches ctrl bits 5:4
  typedef enum logic [1:0] {
    PN_OFF = 2'd0,
    PN_7 = 2'd1,
    PN_15 = 2'd2
  } tpl_pn_sel_e;

  // matches ctrl bit 3
  typedef enum logic {
    FMT_TWOS = 1'b0,
    FMT_OFFSET_BIN = 1'b1
  } tpl_fmt_e;

endpackage

`default_nettype wire

//--- jesd_tpl_deframer.sv
// deframer module that splits a registered link beat into per-channel samples
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_deframer import jesd_tpl_adc_pkg::*; (
  input wire link_clk,
  input wire rst_n,
  input wire adc_rst,

  input wire link_valid,
  input wire [`TPL_LINK_W-1:0] link_data,

  output logic frm_valid,
  output tpl_sample_u [`TPL_NUM_CHANNELS*`TPL_SAMPLES_PER_CH-1:0] frm_data
);

  // ****************************************
  // beat strobe
  // ****************************************

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      frm_valid <= 1'b0;
    end else if (adc_rst) begin
      frm_valid <= 1'b0;
    end else begin
      frm_valid <= link_valid;
    end
  end

  // ****************************************
  // lane and octet mapping
  // ****************************************

  // channel c rides on lane c, the first octet of a sample is its upper byte
  always_ff @(posedge link_clk) begin
    if (link_valid) begin
      for (int l = 0; l < `TPL_NUM_LANES; l++) begin
        for (int k = 0; k < `TPL_SAMPLES_PER_CH; k++) begin
          frm_data[l*`TPL_SAMPLES_PER_CH+k].word <= {
            link_data[l*`TPL_LANE_W + 16*k +: 8],
            link_data[l*`TPL_LANE_W + 16*k + 8 +: 8]
          };
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_tpl_dfmt.sv
// per-channel sample formatter module with offset-binary flip and sign extension
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_dfmt import jesd_tpl_adc_pkg::*; (
  input wire link_clk,
  input wire rst_n,
  input wire adc_rst,

  input wire in_valid,
  input wire tpl_sample_u [`TPL_SAMPLES_PER_CH-1:0] in_data,

  input wire fmt_enable,
  input wire sign_extend,
  input wire tpl_fmt_e fmt_type,
  input wire ch_enable,

  output logic out_valid,
  output logic [`TPL_CH_W-1:0] out_data
);

  // converts one sample, raw word when formatting is off
  function automatic logic [`TPL_NP-1:0] fmt_sample(input tpl_sample_u s);
    logic [`TPL_N-1:0] conv;
    logic msb;
    conv = s.fld.conv;
    if (fmt_type == FMT_OFFSET_BIN) begin
      conv[`TPL_N-1] = ~conv[`TPL_N-1];
    end
    msb = sign_extend & conv[`TPL_N-1];
    if (fmt_enable) begin
      return {{(`TPL_NP-`TPL_N){msb}}, conv};
    end
    return s.word;
  endfunction

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (adc_rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid & ch_enable;
    end
  end

  // sample 0 lands in the low half
  always_ff @(posedge link_clk) begin
    if (in_valid) begin
      for (int k = 0; k < `TPL_SAMPLES_PER_CH; k++) begin
        out_data[k*`TPL_NP +: `TPL_NP] <= fmt_sample(in_data[k]);
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_tpl_pn_mon.sv
// per-channel self-synchronising pn7/pn15 monitor module with error and out-of-sync flags
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_pn_mon import jesd_tpl_adc_pkg::*; (
  input wire link_clk,
  input wire rst_n,

  input wire in_valid,
  input wire tpl_sample_u [`TPL_SAMPLES_PER_CH-1:0] in_data,
  input wire tpl_pn_sel_e pn_sel,

  output logic pn_err,
  output logic pn_oos
);

  // clean beats needed before sync is declared
  localparam int unsigned LOCK_BEATS = 4;

  logic [`TPL_NP-1:0] last_word;
  logic [1:0] lock_cnt;
  logic pn_on;
  logic mismatch;

  // ****************************************
  // prediction
  // ****************************************

  // one word is 16 steps of the fibonacci lfsr, new bit enters at the lsb
  function automatic logic [`TPL_NP-1:0] pn_next(input logic [`TPL_NP-1:0] w);
    logic [`TPL_NP-1:0] s;
    logic fb;
    s = w;
    for (int i = 0; i < `TPL_NP; i++) begin
      if (pn_sel == PN_15) begin
        fb = s[14] ^ s[13];
      end else begin
        fb = s[6] ^ s[5];
      end
      s = {s[`TPL_NP-2:0], fb};
    end
    return s;
  endfunction

  assign pn_on = (pn_sel == PN_7) || (pn_sel == PN_15);

  // sample 0 follows sample 1 of the previous beat
  assign mismatch = (in_data[0].word != pn_next(last_word)) ||
                    (in_data[1].word != pn_next(in_data[0].word));

  always_ff @(posedge link_clk) begin
    if (in_valid) begin
      last_word <= in_data[`TPL_SAMPLES_PER_CH-1].word;
    end
  end

  // ****************************************
  // error and sync tracking
  // ****************************************

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      lock_cnt <= 2'd0;
    end else if (!pn_on) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      lock_cnt <= 2'd0;
    end else begin
      pn_err <= in_valid & mismatch;
      if (in_valid && mismatch) begin
        pn_oos <= 1'b1;
        lock_cnt <= 2'd0;
      end else if (in_valid && pn_oos) begin
        // counter saturates at the last clean beat
        if (lock_cnt == 2'(LOCK_BEATS - 1)) begin
          pn_oos <= 1'b0;
        end else begin
          lock_cnt <= lock_cnt + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_tpl_regmap.sv
// register map module with channel control, software reset and pn status
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_regmap import jesd_tpl_adc_pkg::*; (
  input wire link_clk,
  input wire rst_n,

  input wire up_wr,
  input wire up_rd,
  input wire [7:0] up_addr,
  input wire [31:0] up_wdata,
  output logic [31:0] up_rdata,
  output logic up_rack,

  input wire [`TPL_NUM_CHANNELS-1:0] pn_err,
  input wire [`TPL_NUM_CHANNELS-1:0] pn_oos,

  output logic adc_rst,
  output logic [`TPL_NUM_CHANNELS-1:0] enable,
  output logic [`TPL_NUM_CHANNELS-1:0] dfmt_enable,
  output logic [`TPL_NUM_CHANNELS-1:0] dfmt_sign_extend,
  output tpl_fmt_e [`TPL_NUM_CHANNELS-1:0] dfmt_type,
  output tpl_pn_sel_e [`TPL_NUM_CHANNELS-1:0] pn_sel
);

  logic sw_rst;
  logic [5:0] ctrl [`TPL_NUM_CHANNELS];
  logic [`TPL_NUM_CHANNELS-1:0] pn_sticky;
  logic [31:0] rd_mux;

  assign adc_rst = ~rst_n | sw_rst;

  // ctrl field unpacking
  always_comb begin
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      enable[c] = ctrl[c][0];
      dfmt_enable[c] = ctrl[c][1];
      dfmt_sign_extend[c] = ctrl[c][2];
      dfmt_type[c] = tpl_fmt_e'(ctrl[c][3]);
      pn_sel[c] = tpl_pn_sel_e'(ctrl[c][5:4]);
    end
  end

  // ****************************************
  // write side
  // ****************************************

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_rst <= 1'b0;
      pn_sticky <= '0;
      for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
        ctrl[c] <= 6'd0;
      end
    end else begin
      if (up_wr && (up_addr == `TPL_ADDR_RST)) begin
        sw_rst <= up_wdata[0];
      end
      for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
        if (up_wr && (up_addr == 8'(`TPL_ADDR_CTRL0 + c))) begin
          ctrl[c] <= up_wdata[5:0];
        end
        // a fresh error beats a clear in the same cycle
        if (pn_err[c]) begin
          pn_sticky[c] <= 1'b1;
        end else if (up_wr && (up_addr == 8'(`TPL_ADDR_STAT0 + c)) && up_wdata[0]) begin
          pn_sticky[c] <= 1'b0;
        end
      end
    end
  end

  // ****************************************
  // read side
  // ****************************************

  always_comb begin
    rd_mux = 32'd0;
    if (up_addr == `TPL_ADDR_ID) begin
      rd_mux = `TPL_ID;
    end else if (up_addr == `TPL_ADDR_RST) begin
      rd_mux = {31'd0, sw_rst};
    end
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      if (up_addr == 8'(`TPL_ADDR_CTRL0 + c)) begin
        rd_mux = {26'd0, ctrl[c]};
      end else if (up_addr == 8'(`TPL_ADDR_STAT0 + c)) begin
        rd_mux = {30'd0, pn_oos[c], pn_sticky[c]};
      end
    end
  end

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rd;
    end
  end

  always_ff @(posedge link_clk) begin
    if (up_rd) begin
      up_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- jesd_tpl_adc.sv
// top-level adc transport layer module with deframer, formatters, pn monitors and register map
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_adc import jesd_tpl_adc_pkg::*; (
  // link_clk is the jesd beat clock
  input wire link_clk,
  input wire rst_n,

  input wire link_valid,
  input wire [`TPL_LINK_W-1:0] link_data,

  output logic [`TPL_NUM_CHANNELS-1:0] adc_valid,
  output logic [`TPL_ADC_W-1:0] adc_data,
  output logic adc_rst,

  input wire up_wr,
  input wire up_rd,
  input wire [7:0] up_addr,
  input wire [31:0] up_wdata,
  output logic [31:0] up_rdata,
  output logic up_rack
);

  logic frm_valid;
  tpl_sample_u [`TPL_NUM_CHANNELS*`TPL_SAMPLES_PER_CH-1:0] frm_data;

  logic [`TPL_NUM_CHANNELS-1:0] enable;
  logic [`TPL_NUM_CHANNELS-1:0] dfmt_enable;
  logic [`TPL_NUM_CHANNELS-1:0] dfmt_sign_extend;
  tpl_fmt_e [`TPL_NUM_CHANNELS-1:0] dfmt_type;
  tpl_pn_sel_e [`TPL_NUM_CHANNELS-1:0] pn_sel;
  logic [`TPL_NUM_CHANNELS-1:0] pn_err;
  logic [`TPL_NUM_CHANNELS-1:0] pn_oos;

  jesd_tpl_regmap i_regmap (
    .link_clk (link_clk),
    .rst_n (rst_n),
    .up_wr (up_wr),
    .up_rd (up_rd),
    .up_addr (up_addr),
    .up_wdata (up_wdata),
    .up_rdata (up_rdata),
    .up_rack (up_rack),
    .pn_err (pn_err),
    .pn_oos (pn_oos),
    .adc_rst (adc_rst),
    .enable (enable),
    .dfmt_enable (dfmt_enable),
    .dfmt_sign_extend (dfmt_sign_extend),
    .dfmt_type (dfmt_type),
    .pn_sel (pn_sel)
  );

  jesd_tpl_deframer i_deframer (
    .link_clk (link_clk),
    .rst_n (rst_n),
    .adc_rst (adc_rst),
    .link_valid (link_valid),
    .link_data (link_data),
    .frm_valid (frm_valid),
    .frm_data (frm_data)
  );

  // ****************************************
  // per-channel datapath
  // ****************************************

  for (genvar c = 0; c < `TPL_NUM_CHANNELS; c++) begin : g_ch
    jesd_tpl_dfmt i_dfmt (
      .link_clk (link_clk),
      .rst_n (rst_n),
      .adc_rst (adc_rst),
      .in_valid (frm_valid),
      .in_data (frm_data[c*`TPL_SAMPLES_PER_CH +: `TPL_SAMPLES_PER_CH]),
      .fmt_enable (dfmt_enable[c]),
      .sign_extend (dfmt_sign_extend[c]),
      .fmt_type (dfmt_type[c]),
      .ch_enable (enable[c]),
      .out_valid (adc_valid[c]),
      .out_data (adc_data[c*`TPL_CH_W +: `TPL_CH_W])
    );

    // checks the raw deframed words
    jesd_tpl_pn_mon i_pn_mon (
      .link_clk (link_clk),
      .rst_n (rst_n),
      .in_valid (frm_valid),
      .in_data (frm_data[c*`TPL_SAMPLES_PER_CH +: `TPL_SAMPLES_PER_CH]),
      .pn_sel (pn_sel[c]),
      .pn_err (pn_err[c]),
      .pn_oos (pn_oos[c])
    );
  end

endmodule

`default_nettype wire

//--- jesd_tpl_adc_sva.sv
// bound assertions for adc_valid under reset, up_rack timing and adc_valid source beats
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_adc_sva (
  input wire link_clk,
  input wire rst_n,
  input wire link_valid,
  input wire [`TPL_NUM_CHANNELS-1:0] adc_valid,
  input wire adc_rst,
  input wire up_rd,
  input wire up_rack
);

  // number of assertion failures so far
  int unsigned fail_cnt = 0;

  // one cycle after adc_rst rises the pipeline is flushed
  a_rst_quiet: assert property (@(posedge link_clk) adc_rst && $past(adc_rst) |-> adc_valid == '0)
    else begin
      fail_cnt++;
      $error("adc_valid high while adc_rst is held");
    end

  a_rack: assert property (@(posedge link_clk) disable iff (!rst_n) up_rack == $past(up_rd))
    else begin
      fail_cnt++;
      $error("up_rack does not follow up_rd by one cycle");
    end

  for (genvar c = 0; c < `TPL_NUM_CHANNELS; c++) begin : g_ch
    a_valid_src: assert property (@(posedge link_clk) disable iff (!rst_n)
      adc_valid[c] |-> $past(link_valid, 2))
      else begin
        fail_cnt++;
        $error("adc_valid without a link beat two cycles earlier");
      end
  end

endmodule

bind jesd_tpl_adc jesd_tpl_adc_sva i_sva (
  .link_clk (link_clk),
  .rst_n (rst_n),
  .link_valid (link_valid),
  .adc_valid (adc_valid),
  .adc_rst (adc_rst),
  .up_rd (up_rd),
  .up_rack (up_rack)
);

`default_nettype wire

//--- jesd_tpl_adc_tb.sv
// testbench top with clock, reset, lfsr, pn reference, register tasks and table of test rows
`timescale 1ns/10ps
`default_nettype none

`include "jesd_tpl_adc_config.svh"

module jesd_tpl_adc_tb;

  localparam int TIMEOUT = 50;
  localparam int BEATS = 8;

  typedef enum int {SRC_RAND, SRC_PN} src_e;
  typedef enum int {CLS_DATA, CLS_SWRST, CLS_PN_LOCK, CLS_PN_ERR} cls_e;

  typedef struct {
    string name;
    logic [5:0] ctrl0;
    logic [5:0] ctrl1;
    src_e src;
    cls_e cls;
  } row_t;

  // ctrl bits: 0 enable, 1 dfmt enable, 2 sign extend, 3 offset binary, 5:4 pn select
  row_t rows [11] = '{
    '{"raw_b2b", 6'h01, 6'h01, SRC_RAND, CLS_DATA},
    '{"twos_zero", 6'h03, 6'h03, SRC_RAND, CLS_DATA},
    '{"twos_sext", 6'h07, 6'h07, SRC_RAND, CLS_DATA},
    '{"obin_zero", 6'h0b, 6'h0b, SRC_RAND, CLS_DATA},
    '{"obin_sext", 6'h0f, 6'h0f, SRC_RAND, CLS_DATA},
    '{"mixed_fmt", 6'h0f, 6'h05, SRC_RAND, CLS_DATA},
    '{"ch1_off", 6'h0f, 6'h00, SRC_RAND, CLS_DATA},
    '{"ch0_off", 6'h00, 6'h07, SRC_RAND, CLS_DATA},
    '{"sw_reset", 6'h01, 6'h01, SRC_RAND, CLS_SWRST},
    '{"pn_lock", 6'h21, 6'h11, SRC_PN, CLS_PN_LOCK},
    '{"pn_error", 6'h21, 6'h11, SRC_PN, CLS_PN_ERR}
  };

  logic link_clk;
  logic rst_n;
  logic link_valid;
  logic [63:0] link_data;
  logic [1:0] adc_valid;
  logic [63:0] adc_data;
  logic adc_rst;
  logic up_wr;
  logic up_rd;
  logic [7:0] up_addr;
  logic [31:0] up_wdata;
  logic [31:0] up_rdata;
  logic up_rack;

  string cur_name = "reset";
  logic [5:0] cur_ctrl [2];
  logic [31:0] lfsr;
  logic [15:0] pn_st0;
  logic [15:0] pn_st1;
  int cyc = 0;
  // per channel: {expected observe cycle, expected data}
  logic [63:0] exp_q [2][$];

  jesd_tpl_adc UUT (
    .link_clk (link_clk),
    .rst_n (rst_n),
    .link_valid (link_valid),
    .link_data (link_data),
    .adc_valid (adc_valid),
    .adc_data (adc_data),
    .adc_rst (adc_rst),
    .up_wr (up_wr),
    .up_rd (up_rd),
    .up_addr (up_addr),
    .up_wdata (up_wdata),
    .up_rdata (up_rdata),
    .up_rack (up_rack)
  );

  initial begin
    link_clk = 1'b0;
    forever #2 link_clk = ~link_clk;
  end

  always @(posedge link_clk) cyc <= cyc + 1;

  // ****************************************
  // error reporting
  // ****************************************

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[FAIL] %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
    abort_run();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", cur_name, msg);
    abort_run();
  endtask

  // ****************************************
  // stimulus sources and reference model
  // ****************************************

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // 16 steps, pn15 taps 15/14, pn7 taps 7/6
  function automatic logic [15:0] pn_word(input logic [15:0] w, input logic long);
    logic [15:0] s;
    logic b;
    s = w;
    repeat (16) begin
      b = long ? (s[14] ^ s[13]) : (s[6] ^ s[5]);
      s = {s[14:0], b};
    end
    return s;
  endfunction

  // word i is sample i%2 of lane i/2, first octet carries the upper byte
  function automatic logic [63:0] pack_words(input logic [63:0] words);
    logic [63:0] beat;
    for (int i = 0; i < 4; i++) begin
      beat[16*i +: 8] = words[16*i+8 +: 8];
      beat[16*i+8 +: 8] = words[16*i +: 8];
    end
    return beat;
  endfunction

  function automatic logic [31:0] format_ref(input logic [63:0] beat, input int c,
                                             input logic [5:0] ctrl);
    logic [31:0] lane;
    logic [15:0] w;
    logic [13:0] conv;
    logic [31:0] r;
    lane = beat[32*c +: 32];
    for (int k = 0; k < 2; k++) begin
      w = {lane[8*(2*k) +: 8], lane[8*(2*k+1) +: 8]};
      if (ctrl[1]) begin
        conv = w[15:2];
        if (ctrl[3]) begin
          conv[13] = ~conv[13];
        end
        w = {(ctrl[2] ? {2{conv[13]}} : 2'b00), conv};
      end
      r[16*k +: 16] = w;
    end
    return r;
  endfunction

  task automatic next_beat(input src_e src, output logic [63:0] beat);
    logic [15:0] a0;
    logic [15:0] a1;
    logic [15:0] b0;
    logic [15:0] b1;
    if (src == SRC_RAND) begin
      take_bits(64, beat);
    end else begin
      // channel 0 carries pn15, channel 1 carries pn7
      a0 = pn_word(pn_st0, 1'b1);
      a1 = pn_word(a0, 1'b1);
      b0 = pn_word(pn_st1, 1'b0);
      b1 = pn_word(b0, 1'b0);
      pn_st0 = a1;
      pn_st1 = b1;
      beat = pack_words({b1, b0, a1, a0});
    end
  endtask

  // ****************************************
  // bus tasks
  // ****************************************

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge link_clk);
    up_wr = 1'b1;
    up_addr = addr;
    up_wdata = data;
    @(negedge link_clk);
    up_wr = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string what);
    int n;
    @(negedge link_clk);
    up_rd = 1'b1;
    up_addr = addr;
    n = 0;
    do begin
      @(negedge link_clk);
      up_rd = 1'b0;
      n++;
    end while (!up_rack && n < TIMEOUT);
    assert (up_rack) else report_error({"timeout waiting for up_rack on ", what});
    assert (n == 1) else report_mismatch({what, " rack latency"}, 1, n);
    assert (up_rdata == exp) else report_mismatch(what, exp, up_rdata);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && n < TIMEOUT) begin
      @(negedge link_clk);
      n++;
    end
    assert (exp_q[0].size() == 0 && exp_q[1].size() == 0)
      else report_error("timeout waiting for adc_valid");
  endtask

  // back-to-back beats, optional flip of one bit in channel 0 sample 0 of the first beat
  task automatic send_beats(input src_e src, input int n, input bit expect_out,
                            input bit corrupt);
    logic [63:0] beat;
    for (int i = 0; i < n; i++) begin
      next_beat(src, beat);
      if (corrupt && i == 0) begin
        beat[0] = ~beat[0];
      end
      @(negedge link_clk);
      link_valid = 1'b1;
      link_data = beat;
      for (int c = 0; c < 2; c++) begin
        if (expect_out && cur_ctrl[c][0]) begin
          exp_q[c].push_back({32'(cyc + 2), format_ref(beat, c, cur_ctrl[c])});
        end
      end
    end
    @(negedge link_clk);
    link_valid = 1'b0;
    wait_drain();
  endtask

  task automatic pn_lock(input src_e src);
    send_beats(src, BEATS, 1'b1, 1'b0);
    reg_write(`TPL_ADDR_STAT0, 32'h1);
    reg_write(`TPL_ADDR_STAT0 + 8'd1, 32'h1);
    send_beats(src, BEATS, 1'b1, 1'b0);
    read_check(`TPL_ADDR_STAT0, 32'h0, "stat0 locked");
    read_check(`TPL_ADDR_STAT0 + 8'd1, 32'h0, "stat1 locked");
  endtask

  task automatic pn_error(input src_e src);
    send_beats(src, 1, 1'b1, 1'b1);
    read_check(`TPL_ADDR_STAT0, 32'h3, "stat0 after error");
    read_check(`TPL_ADDR_STAT0 + 8'd1, 32'h0, "stat1 untouched");
    reg_write(`TPL_ADDR_STAT0, 32'h1);
    read_check(`TPL_ADDR_STAT0, 32'h2, "stat0 after clear");
    send_beats(src, 4, 1'b1, 1'b0);
    read_check(`TPL_ADDR_STAT0, 32'h0, "stat0 relocked");
  endtask

  // output monitor, latency and data per channel
  always @(negedge link_clk) begin
    logic [63:0] e;
    if (rst_n) begin
      for (int c = 0; c < 2; c++) begin
        if (adc_valid[c]) begin
          assert (exp_q[c].size() != 0)
            else report_error($sformatf("unexpected adc_valid on channel %0d", c));
          e = exp_q[c].pop_front();
          assert (e[63:32] == 32'(cyc)) else report_mismatch("adc_valid cycle", e[63:32], cyc);
          assert (adc_data[32*c +: 32] == e[31:0])
            else report_mismatch($sformatf("ch%0d data", c), e[31:0], adc_data[32*c +: 32]);
        end
      end
    end
  end

  // bound assertions stop the run at the next falling edge
  always @(negedge link_clk) begin
    assert (UUT.i_sva.fail_cnt == 0) else report_error("a bound assertion failed");
  end

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    rst_n = 1'b0;
    link_valid = 1'b0;
    link_data = '0;
    up_wr = 1'b0;
    up_rd = 1'b0;
    up_addr = 8'd0;
    up_wdata = 32'd0;
    lfsr = 32'hf40126b6;
    pn_st0 = 16'h1234;
    pn_st1 = 16'h0abc;
    repeat (4) @(posedge link_clk);
    @(negedge link_clk);
    assert (adc_rst == 1'b1) else report_mismatch("adc_rst in reset", 1, adc_rst);
    rst_n = 1'b1;

    read_check(`TPL_ADDR_ID, `TPL_ID, "id");
    assert (adc_rst == 1'b0) else report_mismatch("adc_rst after reset", 0, adc_rst);
    read_check(`TPL_ADDR_CTRL0, 32'h0, "ctrl0 reset");
    read_check(`TPL_ADDR_CTRL0 + 8'd1, 32'h0, "ctrl1 reset");
    read_check(`TPL_ADDR_STAT0, 32'h2, "stat0 reset");
    read_check(`TPL_ADDR_STAT0 + 8'd1, 32'h2, "stat1 reset");

    for (int i = 0; i < 11; i++) begin
      cur_name = rows[i].name;
      cur_ctrl[0] = rows[i].ctrl0;
      cur_ctrl[1] = rows[i].ctrl1;
      reg_write(`TPL_ADDR_CTRL0, {26'd0, rows[i].ctrl0});
      reg_write(`TPL_ADDR_CTRL0 + 8'd1, {26'd0, rows[i].ctrl1});
      read_check(`TPL_ADDR_CTRL0, {26'd0, rows[i].ctrl0}, "ctrl0 readback");
      read_check(`TPL_ADDR_CTRL0 + 8'd1, {26'd0, rows[i].ctrl1}, "ctrl1 readback");
      case (rows[i].cls)
        CLS_DATA: send_beats(rows[i].src, BEATS, 1'b1, 1'b0);
        CLS_SWRST: begin
          reg_write(`TPL_ADDR_RST, 32'h1);
          assert (adc_rst == 1'b1) else report_mismatch("adc_rst set", 1, adc_rst);
          read_check(`TPL_ADDR_RST, 32'h1, "rst readback");
          // any adc_valid here hits an empty queue
          send_beats(rows[i].src, BEATS, 1'b0, 1'b0);
          reg_write(`TPL_ADDR_RST, 32'h0);
          assert (adc_rst == 1'b0) else report_mismatch("adc_rst cleared", 0, adc_rst);
          send_beats(rows[i].src, BEATS, 1'b1, 1'b0);
        end
        CLS_PN_LOCK: pn_lock(rows[i].src);
        default: begin
          pn_lock(rows[i].src);
          pn_error(rows[i].src);
        end
      endcase
    end

    if (UUT.i_sva.fail_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_error("a bound assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- jesd_tpl_adc.f
+incdir+.
jesd_tpl_adc_pkg.sv
jesd_tpl_deframer.sv
jesd_tpl_dfmt.sv
jesd_tpl_pn_mon.sv
jesd_tpl_regmap.sv
jesd_tpl_adc.sv
jesd_tpl_adc_sva.sv
jesd_tpl_adc_tb.sv
